/* src.f */
src/ahb_pkg.sv
src/matrix_pkg.sv
src/ahb_input_stage.sv
src/ahb_addr_decoder.sv
src/ahb_output_arbiter.sv
src/ahb_bus_matrix.sv
tests/tb_ahb_slave_model.sv
tests/tb_ahb_bus_matrix.sv

/* Bender.yml */
package:
  name: ahb_bus_matrix

sources:
  - src/ahb_pkg.sv
  - src/matrix_pkg.sv
  - src/ahb_input_stage.sv
  - src/ahb_addr_decoder.sv
  - src/ahb_output_arbiter.sv
  - src/ahb_bus_matrix.sv
  - target: test
    files:
      - tests/tb_ahb_slave_model.sv
      - tests/tb_ahb_bus_matrix.sv

/* tests/tb_ahb_bus_matrix.sv */
module tb_ahb_bus_matrix;

    localparam int TIMEOUT = 50;
    localparam ahb_pkg::haddr_t S0_BASE = 32'h0000_0000;
    localparam ahb_pkg::haddr_t S1_BASE = 32'h2000_0000;
    localparam ahb_pkg::haddr_t UNMAPPED = 32'h4000_0010;
    localparam ahb_pkg::hsize_t WORD_SIZE = 3'b010;

    logic             hclk;
    logic             rst_n;
    ahb_pkg::haddr_t  m_haddr [2];
    ahb_pkg::htrans_t m_htrans [2];
    logic             m_hwrite [2];
    ahb_pkg::hsize_t  m_hsize [2];
    ahb_pkg::hdata_t  m_hwdata [2];
    ahb_pkg::hdata_t  m_hrdata [2];
    logic             m_hready [2];
    ahb_pkg::hresp_t  m_hresp [2];
    logic             s_hsel [2];
    ahb_pkg::haddr_t  s_haddr [2];
    ahb_pkg::htrans_t s_htrans [2];
    logic             s_hwrite [2];
    ahb_pkg::hsize_t  s_hsize [2];
    ahb_pkg::hdata_t  s_hwdata [2];
    logic             s_hready [2];
    ahb_pkg::hdata_t  s_hrdata [2];
    logic             s_hreadyout [2];
    ahb_pkg::hresp_t  s_hresp [2];
    int               errors;
    int               tests_run;
    int               tests_failed;

    ahb_bus_matrix #(
        .S0_BASE    (S0_BASE),
        .S1_BASE    (S1_BASE),
        .SLAVE_MASK (32'hF000_0000)
    ) dut_i (
        .hclk         (hclk),
        .rst_n        (rst_n),
        .m0_haddr     (m_haddr[0]),
        .m0_htrans    (m_htrans[0]),
        .m0_hwrite    (m_hwrite[0]),
        .m0_hsize     (m_hsize[0]),
        .m0_hwdata    (m_hwdata[0]),
        .m0_hrdata    (m_hrdata[0]),
        .m0_hready    (m_hready[0]),
        .m0_hresp     (m_hresp[0]),
        .m1_haddr     (m_haddr[1]),
        .m1_htrans    (m_htrans[1]),
        .m1_hwrite    (m_hwrite[1]),
        .m1_hsize     (m_hsize[1]),
        .m1_hwdata    (m_hwdata[1]),
        .m1_hrdata    (m_hrdata[1]),
        .m1_hready    (m_hready[1]),
        .m1_hresp     (m_hresp[1]),
        .s0_hsel      (s_hsel[0]),
        .s0_haddr     (s_haddr[0]),
        .s0_htrans    (s_htrans[0]),
        .s0_hwrite    (s_hwrite[0]),
        .s0_hsize     (s_hsize[0]),
        .s0_hwdata    (s_hwdata[0]),
        .s0_hready    (s_hready[0]),
        .s0_hrdata    (s_hrdata[0]),
        .s0_hreadyout (s_hreadyout[0]),
        .s0_hresp     (s_hresp[0]),
        .s1_hsel      (s_hsel[1]),
        .s1_haddr     (s_haddr[1]),
        .s1_htrans    (s_htrans[1]),
        .s1_hwrite    (s_hwrite[1]),
        .s1_hsize     (s_hsize[1]),
        .s1_hwdata    (s_hwdata[1]),
        .s1_hready    (s_hready[1]),
        .s1_hrdata    (s_hrdata[1]),
        .s1_hreadyout (s_hreadyout[1]),
        .s1_hresp     (s_hresp[1])
    );

    tb_ahb_slave_model s0_model_i (
        .hclk      (hclk),
        .rst_n     (rst_n),
        .hsel      (s_hsel[0]),
        .haddr     (s_haddr[0]),
        .htrans    (s_htrans[0]),
        .hwrite    (s_hwrite[0]),
        .hwdata    (s_hwdata[0]),
        .hready    (s_hready[0]),
        .hrdata    (s_hrdata[0]),
        .hreadyout (s_hreadyout[0]),
        .hresp     (s_hresp[0])
    );

    tb_ahb_slave_model s1_model_i (
        .hclk      (hclk),
        .rst_n     (rst_n),
        .hsel      (s_hsel[1]),
        .haddr     (s_haddr[1]),
        .htrans    (s_htrans[1]),
        .hwrite    (s_hwrite[1]),
        .hwdata    (s_hwdata[1]),
        .hready    (s_hready[1]),
        .hrdata    (s_hrdata[1]),
        .hreadyout (s_hreadyout[1]),
        .hresp     (s_hresp[1])
    );

    initial hclk = 1'b0;
    always #5 hclk = ~hclk;

    function automatic ahb_pkg::hdata_t word_for(input int m, input ahb_pkg::haddr_t addr);
        return {8'hA0 + 8'(m), addr[23:0]};
    endfunction

    function automatic int log_size(input int s);
        return (s == 0) ? s0_model_i.access_log.size() : s1_model_i.access_log.size();
    endfunction

    function automatic ahb_pkg::haddr_t log_entry(input int s, input int i);
        return (s == 0) ? s0_model_i.access_log[i] : s1_model_i.access_log[i];
    endfunction

    task automatic clear_logs();
        s0_model_i.access_log.delete();
        s1_model_i.access_log.delete();
    endtask

    task automatic report_error(input string msg);
        $display("Fail at %0t: %s", $time, msg);
        errors++;
    endtask

    task automatic print_counts();
        $display("Summary: %0d tests run, %0d failed, %0d errors", tests_run, tests_failed,
                 errors);
    endtask

    task automatic end_test(input string name, input int errs_before);
        tests_run++;
        if (errors != errs_before) begin
            tests_failed++;
        end
        $display("%-16s finished with %0d errors", name, errors - errs_before);
    endtask

    // Every address phase a slave accepts is a word access
    always @(posedge hclk) begin
        for (int s = 0; s < 2; s++) begin
            if (rst_n && s_hsel[s] && s_hready[s] && s_htrans[s] != ahb_pkg::IDLE &&
                s_hsize[s] != WORD_SIZE) begin
                report_error($sformatf("s%0d hsize %b, expected %b", s, s_hsize[s],
                                       WORD_SIZE));
            end
        end
    end

    // Called on a falling edge, returns on the falling edge before an hready-high edge
    task automatic wait_ready(input int m);
        int cycles;
        cycles = 0;
        while (!m_hready[m] && cycles < TIMEOUT) begin
            cycles++;
            @(negedge hclk);
        end
        if (!m_hready[m]) begin
            $display("Timeout: master %0d saw no hready within %0d cycles", m, TIMEOUT);
            print_counts();
            $display("TEST FAILED");
            $finish;
        end
    endtask

    task automatic transfer(input int m, input ahb_pkg::haddr_t addr, input logic write,
                            input ahb_pkg::hdata_t wdata, output ahb_pkg::hdata_t rdata,
                            output ahb_pkg::hresp_t resp);
        m_haddr[m]  = addr;
        m_htrans[m] = ahb_pkg::NONSEQ;
        m_hwrite[m] = write;
        m_hsize[m]  = WORD_SIZE;
        wait_ready(m);
        @(negedge hclk);
        m_htrans[m] = ahb_pkg::IDLE;
        m_hsize[m]  = '0;
        m_hwdata[m] = wdata;
        wait_ready(m);
        rdata = m_hrdata[m];
        resp  = m_hresp[m];
        @(negedge hclk);
    endtask

    // Four-beat incrementing write, address and data phases overlap
    task automatic burst_write(input int m, input ahb_pkg::haddr_t base);
        for (int i = 0; i < 4; i++) begin
            m_haddr[m]  = base + 32'(i) * 4;
            m_hwrite[m] = 1'b1;
            m_hsize[m]  = WORD_SIZE;
            if (i == 0) begin
                m_htrans[m] = ahb_pkg::NONSEQ;
            end else begin
                m_htrans[m] = ahb_pkg::SEQ;
            end
            wait_ready(m);
            @(negedge hclk);
            m_hwdata[m] = word_for(m, base + 32'(i) * 4);
        end
        m_htrans[m] = ahb_pkg::IDLE;
        m_hsize[m]  = '0;
        wait_ready(m);
        @(negedge hclk);
    endtask

    task automatic reset_values();
        int errs;
        errs = errors;
        @(negedge hclk);
        if (s_hsel[0] || s_hsel[1]) begin
            report_error("slave hsel high after reset");
        end
        if (s_htrans[0] != ahb_pkg::IDLE || s_htrans[1] != ahb_pkg::IDLE) begin
            report_error("slave htrans not IDLE after reset");
        end
        for (int m = 0; m < 2; m++) begin
            if (!m_hready[m] || m_hresp[m] != ahb_pkg::OKAY) begin
                report_error($sformatf("m%0d hready %b hresp %b after reset", m,
                                       m_hready[m], m_hresp[m]));
            end
        end
        end_test("reset", errs);
    endtask

    task automatic write_read_all();
        int              errs;
        ahb_pkg::haddr_t addr;
        ahb_pkg::hdata_t rdata;
        ahb_pkg::hresp_t resp;
        errs = errors;
        for (int m = 0; m < 2; m++) begin
            for (int s = 0; s < 2; s++) begin
                for (int k = 0; k < 3; k++) begin
                    addr = ((s == 0) ? S0_BASE : S1_BASE) + 32'h100 + 32'(m) * 32'h40 +
                           32'(k) * 4;
                    transfer(m, addr, 1'b1, word_for(m, addr), rdata, resp);
                    transfer(m, addr, 1'b0, 32'h0, rdata, resp);
                    if (rdata != word_for(m, addr) || resp != ahb_pkg::OKAY) begin
                        report_error($sformatf("m%0d read %h at %h, expected %h", m, rdata,
                                               addr, word_for(m, addr)));
                    end
                end
            end
        end
        end_test("write_read", errs);
    endtask

    task automatic unmapped_error();
        int errs;
        errs = errors;
        clear_logs();
        for (int m = 0; m < 2; m++) begin
            m_haddr[m]  = UNMAPPED;
            m_htrans[m] = ahb_pkg::NONSEQ;
            m_hwrite[m] = 1'b0;
            wait_ready(m);
            if (s_hsel[0] || s_hsel[1]) begin
                report_error($sformatf("slave selected for unmapped access from m%0d", m));
            end
            @(negedge hclk);
            m_htrans[m] = ahb_pkg::IDLE;
            if (m_hresp[m] != ahb_pkg::ERROR || m_hready[m]) begin
                report_error($sformatf("m%0d first error cycle hresp %b hready %b", m,
                                       m_hresp[m], m_hready[m]));
            end
            @(negedge hclk);
            if (m_hresp[m] != ahb_pkg::ERROR || !m_hready[m]) begin
                report_error($sformatf("m%0d second error cycle hresp %b hready %b", m,
                                       m_hresp[m], m_hready[m]));
            end
            @(negedge hclk);
        end
        if (log_size(0) != 0 || log_size(1) != 0) begin
            report_error("a slave accepted the unmapped access");
        end
        end_test("unmapped", errs);
    endtask

    task automatic same_slave_contention();
        int              errs;
        ahb_pkg::haddr_t a0;
        ahb_pkg::haddr_t a1;
        ahb_pkg::hdata_t rd0;
        ahb_pkg::hdata_t rd1;
        ahb_pkg::hresp_t rs0;
        ahb_pkg::hresp_t rs1;
        errs = errors;
        a0   = S0_BASE + 32'h200;
        a1   = S0_BASE + 32'h204;
        clear_logs();
        fork
            transfer(0, a0, 1'b1, word_for(0, a0), rd0, rs0);
            transfer(1, a1, 1'b1, word_for(1, a1), rd1, rs1);
        join
        if (log_size(0) != 2 || log_entry(0, 0) != a0 || log_entry(0, 1) != a1) begin
            report_error("s0 did not see m0 before m1");
        end
        fork
            transfer(0, a0, 1'b0, 32'h0, rd0, rs0);
            transfer(1, a1, 1'b0, 32'h0, rd1, rs1);
        join
        if (rd0 != word_for(0, a0) || rd1 != word_for(1, a1)) begin
            report_error($sformatf("contention read back %h %h", rd0, rd1));
        end
        end_test("contention", errs);
    endtask

    task automatic burst_hold();
        int              errs;
        ahb_pkg::haddr_t base;
        ahb_pkg::haddr_t a0;
        ahb_pkg::hdata_t rdata;
        ahb_pkg::hresp_t resp;
        errs = errors;
        base = S0_BASE + 32'h300;
        a0   = S0_BASE + 32'h380;
        clear_logs();
        fork
            burst_write(1, base);
            begin
                @(negedge hclk);
                transfer(0, a0, 1'b1, word_for(0, a0), rdata, resp);
            end
        join
        if (log_size(0) != 5) begin
            report_error($sformatf("s0 logged %0d transfers, expected 5", log_size(0)));
        end
        for (int i = 0; i < 4; i++) begin
            if (log_entry(0, i) != base + 32'(i) * 4) begin
                report_error($sformatf("s0 log entry %0d is %h", i, log_entry(0, i)));
            end
        end
        if (log_entry(0, 4) != a0) begin
            report_error($sformatf("m0 address after burst is %h", log_entry(0, 4)));
        end
        // Burst data must come from m1 even though m0 owned the next address phase
        for (int i = 0; i < 4; i++) begin
            transfer(0, base + 32'(i) * 4, 1'b0, 32'h0, rdata, resp);
            if (rdata != word_for(1, base + 32'(i) * 4)) begin
                report_error($sformatf("burst beat %0d read %h", i, rdata));
            end
        end
        end_test("burst_hold", errs);
    endtask

    task automatic parallel_slaves();
        int              errs;
        ahb_pkg::haddr_t a0;
        ahb_pkg::haddr_t a1;
        ahb_pkg::hdata_t rd0;
        ahb_pkg::hdata_t rd1;
        ahb_pkg::hresp_t rs0;
        ahb_pkg::hresp_t rs1;
        errs = errors;
        a0   = S0_BASE + 32'h400;
        a1   = S1_BASE + 32'h400;
        clear_logs();
        fork
            transfer(0, a0, 1'b1, word_for(0, a0), rd0, rs0);
            transfer(1, a1, 1'b1, word_for(1, a1), rd1, rs1);
        join
        fork
            transfer(0, a0, 1'b0, 32'h0, rd0, rs0);
            transfer(1, a1, 1'b0, 32'h0, rd1, rs1);
        join
        if (rd0 != word_for(0, a0) || rd1 != word_for(1, a1)) begin
            report_error($sformatf("parallel read back %h %h", rd0, rd1));
        end
        if (log_size(0) != 2 || log_size(1) != 2) begin
            report_error("slave log sizes wrong for parallel access");
        end
        for (int i = 0; i < 2; i++) begin
            if (log_entry(0, i) != a0 || log_entry(1, i) != a1) begin
                report_error($sformatf("slave saw foreign address in entry %0d", i));
            end
        end
        end_test("parallel", errs);
    endtask

    initial begin
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        rst_n        = 1'b0;
        for (int m = 0; m < 2; m++) begin
            m_haddr[m]  = '0;
            m_htrans[m] = ahb_pkg::IDLE;
            m_hwrite[m] = 1'b0;
            m_hsize[m]  = '0;
            m_hwdata[m] = '0;
        end
        repeat (8) @(negedge hclk);
        rst_n = 1'b1;
        reset_values();
        write_read_all();
        unmapped_error();
        same_slave_contention();
        burst_hold();
        parallel_slaves();
        print_counts();
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

/* tests/tb_ahb_slave_model.sv */
module tb_ahb_slave_model (
    input  logic             hclk,
    input  logic             rst_n,
    input  logic             hsel,
    input  ahb_pkg::haddr_t  haddr,
    input  ahb_pkg::htrans_t htrans,
    input  logic             hwrite,
    input  ahb_pkg::hdata_t  hwdata,
    input  logic             hready,
    output ahb_pkg::hdata_t  hrdata,
    output logic             hreadyout,
    output ahb_pkg::hresp_t  hresp
);

    ahb_pkg::hdata_t mem [256];
    ahb_pkg::haddr_t access_log [$];
    logic [15:0]     lfsr_q;
    logic            dp_valid;
    logic            dp_write;
    ahb_pkg::haddr_t dp_addr;
    int              wait_left;
    int              new_waits;

    // Galois form, x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] state);
        return state[0] ? ((state >> 1) ^ 16'hB400) : (state >> 1);
    endfunction

    // Zero to three wait states, one step per bit
    function automatic int draw_waits();
        int waits;
        waits = 0;
        for (int i = 0; i < 2; i++) begin
            lfsr_q = lfsr_next(lfsr_q);
            waits  = (waits << 1) | int'(lfsr_q[0]);
        end
        return waits;
    endfunction

    initial begin
        for (int i = 0; i < 256; i++) begin
            mem[i] = 32'h5A5A_0000 | (32'(i) * 4);
        end
    end

    assign hresp  = ahb_pkg::OKAY;
    assign hrdata = (dp_valid && !dp_write) ? mem[dp_addr[9:2]] : '0;

    always @(posedge hclk) begin
        if (!rst_n) begin
            lfsr_q     = 16'd44;
            dp_valid  <= 1'b0;
            dp_write  <= 1'b0;
            dp_addr   <= '0;
            hreadyout <= 1'b1;
            wait_left <= 0;
        end else if (hreadyout) begin
            // Data phase of the previous transfer ends on this edge
            if (dp_valid && dp_write) begin
                mem[dp_addr[9:2]] <= hwdata;
            end
            dp_valid <= 1'b0;
            if (hsel && hready && (htrans == ahb_pkg::NONSEQ || htrans == ahb_pkg::SEQ)) begin
                new_waits = draw_waits();
                access_log.push_back(haddr);
                dp_valid  <= 1'b1;
                dp_addr   <= haddr;
                dp_write  <= hwrite;
                wait_left <= new_waits;
                hreadyout <= (new_waits == 0);
            end
        end else begin
            if (wait_left <= 1) begin
                hreadyout <= 1'b1;
            end
            wait_left <= wait_left - 1;
        end
    end

endmodule

/* src/ahb_bus_matrix.sv */
module ahb_bus_matrix #(
    parameter ahb_pkg::haddr_t S0_BASE    = 32'h0000_0000,
    parameter ahb_pkg::haddr_t S1_BASE    = 32'h2000_0000,
    parameter ahb_pkg::haddr_t SLAVE_MASK = 32'hF000_0000
) (
    input  logic             hclk,
    input  logic             rst_n,

    // Master 0
    input  ahb_pkg::haddr_t  m0_haddr,
    input  ahb_pkg::htrans_t m0_htrans,
    input  logic             m0_hwrite,
    input  ahb_pkg::hsize_t  m0_hsize,
    input  ahb_pkg::hdata_t  m0_hwdata,
    output ahb_pkg::hdata_t  m0_hrdata,
    output logic             m0_hready,
    output ahb_pkg::hresp_t  m0_hresp,

    // Master 1
    input  ahb_pkg::haddr_t  m1_haddr,
    input  ahb_pkg::htrans_t m1_htrans,
    input  logic             m1_hwrite,
    input  ahb_pkg::hsize_t  m1_hsize,
    input  ahb_pkg::hdata_t  m1_hwdata,
    output ahb_pkg::hdata_t  m1_hrdata,
    output logic             m1_hready,
    output ahb_pkg::hresp_t  m1_hresp,

    // Slave 0
    output logic             s0_hsel,
    output ahb_pkg::haddr_t  s0_haddr,
    output ahb_pkg::htrans_t s0_htrans,
    output logic             s0_hwrite,
    output ahb_pkg::hsize_t  s0_hsize,
    output ahb_pkg::hdata_t  s0_hwdata,
    output logic             s0_hready,
    input  ahb_pkg::hdata_t  s0_hrdata,
    input  logic             s0_hreadyout,
    input  ahb_pkg::hresp_t  s0_hresp,

    // Slave 1
    output logic             s1_hsel,
    output ahb_pkg::haddr_t  s1_haddr,
    output ahb_pkg::htrans_t s1_htrans,
    output logic             s1_hwrite,
    output ahb_pkg::hsize_t  s1_hsize,
    output ahb_pkg::hdata_t  s1_hwdata,
    output logic             s1_hready,
    input  ahb_pkg::hdata_t  s1_hrdata,
    input  logic             s1_hreadyout,
    input  ahb_pkg::hresp_t  s1_hresp
);

    ahb_pkg::haddr_t        req_addr [matrix_pkg::NUM_MASTERS];
    ahb_pkg::htrans_t       req_trans [matrix_pkg::NUM_MASTERS];
    logic                   req_write [matrix_pkg::NUM_MASTERS];
    ahb_pkg::hsize_t        req_size [matrix_pkg::NUM_MASTERS];
    logic                   req_held [matrix_pkg::NUM_MASTERS];
    logic                   req_done [matrix_pkg::NUM_MASTERS];
    matrix_pkg::slave_sel_t req_sel [matrix_pkg::NUM_MASTERS];
    matrix_pkg::slave_sel_t granted [matrix_pkg::NUM_MASTERS];
    ahb_pkg::hdata_t        m_hwdata [2];
    logic                   sel_s0 [matrix_pkg::NUM_MASTERS];
    logic                   sel_s1 [matrix_pkg::NUM_MASTERS];
    logic                   grant_s0 [matrix_pkg::NUM_MASTERS];
    logic                   grant_s1 [matrix_pkg::NUM_MASTERS];
    logic                   s_hready [2];
    ahb_pkg::hresp_t        s_hresp [2];
    ahb_pkg::hdata_t        s_hrdata [2];

    assign m_hwdata[0] = m0_hwdata;
    assign m_hwdata[1] = m1_hwdata;
    assign s_hready[0] = s0_hready;
    assign s_hready[1] = s1_hready;
    assign s_hresp[0]  = s0_hresp;
    assign s_hresp[1]  = s1_hresp;
    assign s_hrdata[0] = s0_hrdata;
    assign s_hrdata[1] = s1_hrdata;

    // Cross the per-master selects into per-slave requests
    assign sel_s0[0]  = req_sel[0][0];
    assign sel_s0[1]  = req_sel[1][0];
    assign sel_s1[0]  = req_sel[0][1];
    assign sel_s1[1]  = req_sel[1][1];
    assign granted[0] = {grant_s1[0], grant_s0[0]};
    assign granted[1] = {grant_s1[1], grant_s0[1]};

    ahb_input_stage in_m0_i (
        .hclk      (hclk),
        .rst_n     (rst_n),
        .haddr     (m0_haddr),
        .htrans    (m0_htrans),
        .hwrite    (m0_hwrite),
        .hsize     (m0_hsize),
        .hready    (m0_hready),
        .req_addr  (req_addr[0]),
        .req_trans (req_trans[0]),
        .req_write (req_write[0]),
        .req_size  (req_size[0]),
        .req_held  (req_held[0]),
        .req_done  (req_done[0])
    );

    ahb_input_stage in_m1_i (
        .hclk      (hclk),
        .rst_n     (rst_n),
        .haddr     (m1_haddr),
        .htrans    (m1_htrans),
        .hwrite    (m1_hwrite),
        .hsize     (m1_hsize),
        .hready    (m1_hready),
        .req_addr  (req_addr[1]),
        .req_trans (req_trans[1]),
        .req_write (req_write[1]),
        .req_size  (req_size[1]),
        .req_held  (req_held[1]),
        .req_done  (req_done[1])
    );

    ahb_addr_decoder #(
        .S0_BASE    (S0_BASE),
        .S1_BASE    (S1_BASE),
        .SLAVE_MASK (SLAVE_MASK)
    ) dec_m0_i (
        .hclk        (hclk),
        .rst_n       (rst_n),
        .req_addr    (req_addr[0]),
        .req_trans   (req_trans[0]),
        .req_held    (req_held[0]),
        .req_sel     (req_sel[0]),
        .granted     (granted[0]),
        .s_hreadyout (s_hready),
        .s_hresp     (s_hresp),
        .s_hrdata    (s_hrdata),
        .req_done    (req_done[0]),
        .hready      (m0_hready),
        .hresp       (m0_hresp),
        .hrdata      (m0_hrdata)
    );

    ahb_addr_decoder #(
        .S0_BASE    (S0_BASE),
        .S1_BASE    (S1_BASE),
        .SLAVE_MASK (SLAVE_MASK)
    ) dec_m1_i (
        .hclk        (hclk),
        .rst_n       (rst_n),
        .req_addr    (req_addr[1]),
        .req_trans   (req_trans[1]),
        .req_held    (req_held[1]),
        .req_sel     (req_sel[1]),
        .granted     (granted[1]),
        .s_hreadyout (s_hready),
        .s_hresp     (s_hresp),
        .s_hrdata    (s_hrdata),
        .req_done    (req_done[1]),
        .hready      (m1_hready),
        .hresp       (m1_hresp),
        .hrdata      (m1_hrdata)
    );

    ahb_output_arbiter arb_s0_i (
        .hclk      (hclk),
        .rst_n     (rst_n),
        .sel       (sel_s0),
        .req_trans (req_trans),
        .req_addr  (req_addr),
        .req_write (req_write),
        .req_size  (req_size),
        .m_hwdata  (m_hwdata),
        .hreadyout (s0_hreadyout),
        .grant     (grant_s0),
        .hsel      (s0_hsel),
        .haddr     (s0_haddr),
        .htrans    (s0_htrans),
        .hwrite    (s0_hwrite),
        .hsize     (s0_hsize),
        .hwdata    (s0_hwdata),
        .hready    (s0_hready)
    );

    ahb_output_arbiter arb_s1_i (
        .hclk      (hclk),
        .rst_n     (rst_n),
        .sel       (sel_s1),
        .req_trans (req_trans),
        .req_addr  (req_addr),
        .req_write (req_write),
        .req_size  (req_size),
        .m_hwdata  (m_hwdata),
        .hreadyout (s1_hreadyout),
        .grant     (grant_s1),
        .hsel      (s1_hsel),
        .haddr     (s1_haddr),
        .htrans    (s1_htrans),
        .hwrite    (s1_hwrite),
        .hsize     (s1_hsize),
        .hwdata    (s1_hwdata),
        .hready    (s1_hready)
    );

endmodule

/* src/ahb_output_arbiter.sv */
module ahb_output_arbiter (
    input  logic             hclk,
    input  logic             rst_n,
    input  logic             sel [matrix_pkg::NUM_MASTERS],
    input  ahb_pkg::htrans_t req_trans [matrix_pkg::NUM_MASTERS],
    input  ahb_pkg::haddr_t  req_addr [matrix_pkg::NUM_MASTERS],
    input  logic             req_write [matrix_pkg::NUM_MASTERS],
    input  ahb_pkg::hsize_t  req_size [matrix_pkg::NUM_MASTERS],
    input  ahb_pkg::hdata_t  m_hwdata [2],
    input  logic             hreadyout,
    output logic             grant [matrix_pkg::NUM_MASTERS],
    output logic             hsel,
    output ahb_pkg::haddr_t  haddr,
    output ahb_pkg::htrans_t htrans,
    output logic             hwrite,
    output ahb_pkg::hsize_t  hsize,
    output ahb_pkg::hdata_t  hwdata,
    output logic             hready
);

    matrix_pkg::arb_state_t  state_q;
    matrix_pkg::master_idx_t owner_q;
    matrix_pkg::master_idx_t win;
    matrix_pkg::master_idx_t gidx;
    logic                    any_req;
    logic                    owner_seq;
    logic                    hold;

    // Lowest index wins
    always_comb begin
        win     = '0;
        any_req = 1'b0;
        for (int i = matrix_pkg::NUM_MASTERS - 1; i >= 0; i--) begin
            if (sel[i]) begin
                win     = matrix_pkg::master_idx_t'(i);
                any_req = 1'b1;
            end
        end
    end

    assign owner_seq = req_trans[owner_q] == ahb_pkg::SEQ ||
                       req_trans[owner_q] == ahb_pkg::BUSY;
    assign hold      = (state_q == matrix_pkg::ARB_OWN) && owner_seq;
    assign gidx      = hold ? owner_q : win;

    always_comb begin
        for (int i = 0; i < matrix_pkg::NUM_MASTERS; i++) begin
            grant[i] = (hold || any_req) && (gidx == matrix_pkg::master_idx_t'(i));
        end
    end

    assign hsel   = (hold || any_req) && sel[gidx];
    assign haddr  = req_addr[gidx];
    assign htrans = hsel ? req_trans[gidx] : ahb_pkg::IDLE;
    assign hwrite = req_write[gidx];
    assign hsize  = req_size[gidx];
    assign hready = hreadyout;

    // Write data follows the data phase, not the address phase
    assign hwdata = (state_q == matrix_pkg::ARB_IDLE) ? '0 : m_hwdata[owner_q];

    always_ff @(posedge hclk) begin
        if (!rst_n) begin
            state_q <= matrix_pkg::ARB_IDLE;
            owner_q <= '0;
        end else if (hreadyout) begin
            if (hsel) begin
                state_q <= matrix_pkg::ARB_OWN;
                owner_q <= gidx;
            end else if (hold) begin
                state_q <= matrix_pkg::ARB_OWN;
            end else begin
                state_q <= matrix_pkg::ARB_IDLE;
            end
        end else if (state_q == matrix_pkg::ARB_OWN && !owner_seq) begin
            // Burst over, only the stalled data phase remains
            state_q <= matrix_pkg::ARB_DATA;
        end
    end

    grant_onehot_a: assert property (@(posedge hclk) disable iff (!rst_n)
        $onehot0({grant[1], grant[0]}));

    // Slave sees SEQ only from the master that owns the burst
    seq_owner_a: assert property (@(posedge hclk) disable iff (!rst_n)
        hsel && htrans == ahb_pkg::SEQ |-> state_q == matrix_pkg::ARB_OWN);

endmodule

/* src/ahb_addr_decoder.sv */
module ahb_addr_decoder #(
    parameter ahb_pkg::haddr_t S0_BASE    = 32'h0000_0000,
    parameter ahb_pkg::haddr_t S1_BASE    = 32'h2000_0000,
    parameter ahb_pkg::haddr_t SLAVE_MASK = 32'hF000_0000
) (
    input  logic                  hclk,
    input  logic                  rst_n,
    input  ahb_pkg::haddr_t       req_addr,
    input  ahb_pkg::htrans_t      req_trans,
    input  logic                  req_held,
    output matrix_pkg::slave_sel_t req_sel,
    input  matrix_pkg::slave_sel_t granted,
    input  logic                  s_hreadyout [2],
    input  ahb_pkg::hresp_t       s_hresp [2],
    input  ahb_pkg::hdata_t       s_hrdata [2],
    output logic                  req_done,
    output logic                  hready,
    output ahb_pkg::hresp_t       hresp,
    output ahb_pkg::hdata_t       hrdata
);

    matrix_pkg::slave_sel_t decoded;
    matrix_pkg::slave_sel_t dp_sel_q;
    matrix_pkg::slave_sel_t accept;
    logic                   dp_unmapped_q;
    logic                   err_second_q;
    logic                   dp_ready;
    logic                   req_valid;

    always_comb begin
        decoded = '0;
        if ((req_addr & SLAVE_MASK) == S0_BASE) begin
            decoded[0] = 1'b1;
        end else if ((req_addr & SLAVE_MASK) == S1_BASE) begin
            decoded[1] = 1'b1;
        end
    end

    // A live request only counts once the master's previous data phase is done
    assign req_valid = (req_held || dp_ready) &&
                       (req_trans == ahb_pkg::NONSEQ || req_trans == ahb_pkg::SEQ);
    assign req_sel   = req_valid ? decoded : '0;

    assign accept[0] = granted[0] && s_hreadyout[0];
    assign accept[1] = granted[1] && s_hreadyout[1];

    // Unmapped requests go to the default slave
    assign req_done = req_valid && ((decoded == '0) ? dp_ready : |(req_sel & accept));

    always_comb begin
        dp_ready = 1'b1;
        hresp    = ahb_pkg::OKAY;
        hrdata   = '0;
        if (dp_sel_q[0]) begin
            dp_ready = s_hreadyout[0];
            hresp    = s_hresp[0];
            hrdata   = s_hrdata[0];
        end else if (dp_sel_q[1]) begin
            dp_ready = s_hreadyout[1];
            hresp    = s_hresp[1];
            hrdata   = s_hrdata[1];
        end else if (dp_unmapped_q) begin
            // Two-cycle ERROR
            dp_ready = err_second_q;
            hresp    = ahb_pkg::ERROR;
        end
    end

    assign hready = dp_ready && !req_held;

    always_ff @(posedge hclk) begin
        if (!rst_n) begin
            dp_sel_q      <= '0;
            dp_unmapped_q <= 1'b0;
            err_second_q  <= 1'b0;
        end else if (dp_ready) begin
            dp_sel_q      <= req_done ? req_sel : '0;
            dp_unmapped_q <= req_done && (req_sel == '0);
            err_second_q  <= 1'b0;
        end else if (dp_unmapped_q) begin
            err_second_q  <= 1'b1;
        end
    end

endmodule

/* src/ahb_input_stage.sv */
module ahb_input_stage (
    input  logic             hclk,
    input  logic             rst_n,
    input  ahb_pkg::haddr_t  haddr,
    input  ahb_pkg::htrans_t htrans,
    input  logic             hwrite,
    input  ahb_pkg::hsize_t  hsize,
    input  logic             hready,
    output ahb_pkg::haddr_t  req_addr,
    output ahb_pkg::htrans_t req_trans,
    output logic             req_write,
    output ahb_pkg::hsize_t  req_size,
    output logic             req_held,
    input  logic             req_done
);

    logic             held_q;
    ahb_pkg::haddr_t  addr_q;
    ahb_pkg::htrans_t trans_q;
    logic             write_q;
    ahb_pkg::hsize_t  size_q;
    logic             live_active;

    // Address phase on the master bus completes this cycle
    assign live_active = hready &&
                         (htrans == ahb_pkg::NONSEQ || htrans == ahb_pkg::SEQ);

    always_ff @(posedge hclk) begin
        if (!rst_n) begin
            held_q <= 1'b0;
        end else if (held_q) begin
            if (req_done) begin
                held_q <= 1'b0;
            end
        end else if (live_active && !req_done) begin
            held_q <= 1'b1;
        end
    end

    // Payload copy, only meaningful while held_q is set
    always_ff @(posedge hclk) begin
        if (!held_q && live_active) begin
            addr_q  <= haddr;
            trans_q <= htrans;
            write_q <= hwrite;
            size_q  <= hsize;
        end
    end

    // Granted transfers pass straight through
    assign req_addr  = held_q ? addr_q  : haddr;
    assign req_trans = held_q ? trans_q : htrans;
    assign req_write = held_q ? write_q : hwrite;
    assign req_size  = held_q ? size_q  : hsize;
    assign req_held  = held_q;

    // Held request must not move until a slave takes it
    held_stable_a: assert property (@(posedge hclk) disable iff (!rst_n)
        held_q && !req_done |=> held_q && req_addr == $past(req_addr) &&
                                req_trans == $past(req_trans));

    // Master stays stalled while its request waits for a grant
    held_stall_a: assert property (@(posedge hclk) disable iff (!rst_n)
        held_q |-> !hready);

endmodule

/* src/matrix_pkg.sv */
package matrix_pkg;

    localparam int NUM_MASTERS = 2;

    typedef logic [0:0] master_idx_t;

    // One bit per slave, all zero means no slave is mapped
    typedef logic [1:0] slave_sel_t;

    typedef enum logic [1:0] {
        ARB_IDLE = 2'b00,
        ARB_OWN  = 2'b01,
        ARB_DATA = 2'b10
    } arb_state_t;

endpackage

/* src/ahb_pkg.sv */
package ahb_pkg;

    // Address and data buses
    typedef logic [31:0] haddr_t;
    typedef logic [31:0] hdata_t;

    // Transfer size, byte to word
    typedef logic [2:0] hsize_t;

    typedef enum logic [1:0] {
        IDLE   = 2'b00,
        BUSY   = 2'b01,
        NONSEQ = 2'b10,
        SEQ    = 2'b11
    } htrans_t;

    // AHB-lite only needs the low bit of the full response
    typedef enum logic {
        OKAY  = 1'b0,
        ERROR = 1'b1
    } hresp_t;

endpackage
